//--- cordic_pkg.sv
`default_nettype none

package cordic_pkg;

   localparam int unsigned PHASE_W = 16;                 // phase word, one full turn
   localparam int unsigned DATA_W  = 18;                 // signed x, y, angle and results
   localparam int unsigned ITER_N  = 16;                 // micro-rotations per result
   localparam int unsigned CNT_W   = 5;                  // holds 0 .. ITER_N

   localparam logic [18:0] TWO_PI_Q16 = 19'd411775;      // 2*pi * 2^16, rounded
   localparam logic signed [DATA_W-1:0] CORDIC_K_Q16 = 18'sd39797;  // 0.607253 in Q1.16

   typedef enum logic [1:0] {
      Q0,                                                // 0 .. pi/2
      Q1,                                                // pi/2 .. pi
      Q2,                                                // pi .. 3pi/2
      Q3                                                 // 3pi/2 .. 2pi
   } quadrant_e;

   typedef enum logic [1:0] {
      IDLE,                                              // waiting for start
      ROTATE,                                            // micro-rotations in progress
      DONE                                               // x/y hold cos/sin
   } rot_state_e;

   // arctan(2^-i) in 2^-16 rad
   function automatic logic signed [DATA_W-1:0] atan_lut(input logic [CNT_W-1:0] i);
      logic signed [DATA_W-1:0] a;
      case (i)
         5'd0:    a = 18'sh0c90f;                        // pi/4
         5'd1:    a = 18'sh076b1;
         5'd2:    a = 18'sh03eb6;
         5'd3:    a = 18'sh01fd5;
         5'd4:    a = 18'sh00ffa;
         5'd5:    a = 18'sh007ff;                        // from here close to 2^-i
         5'd6:    a = 18'sh003ff;
         5'd7:    a = 18'sh001ff;
         5'd8:    a = 18'sh000ff;
         5'd9:    a = 18'sh0007f;
         5'd10:   a = 18'sh0003f;
         5'd11:   a = 18'sh0001f;
         5'd12:   a = 18'sh0000f;
         5'd13:   a = 18'sh00007;
         5'd14:   a = 18'sh00003;
         5'd15:   a = 18'sh00001;                        // last useful step
         default: a = '0;
      endcase
      return a;
   endfunction

endpackage

`default_nettype wire

//--- cordic_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cordic_if import cordic_pkg::*; ();

   logic signed [DATA_W-1:0] angle;                      // target angle, first quadrant
   quadrant_e                quadrant;                   // quadrant of the phase
   logic                     start;                      // request level, registered
   logic                     abort;                      // request gone, clear everything
   logic                     done;                       // x/y final
   logic signed [DATA_W-1:0] x;                          // cos, first quadrant
   logic signed [DATA_W-1:0] y;                          // sin, first quadrant

   modport fold (
      output angle, quadrant, start, abort
   );

   modport rot (
      input  angle, start, abort,
      output x, y, done
   );

   modport unfold (
      input  quadrant, x, y, done, abort
   );

endinterface

`default_nettype wire

//--- phase_fold.sv
`timescale 1ns/1ps
`default_nettype none

module phase_fold import cordic_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_req,
   input  logic [PHASE_W-1:0] i_phase,
   cordic_if.fold             fold
);

   localparam int unsigned FRAC_W = 16;                  // radian fraction bits
   localparam int unsigned PROD_W = PHASE_W - 2 + $bits(TWO_PI_Q16);

   logic                     req_q;                      // request seen on last edge
   logic                     capture;                    // first sampled request edge
   logic [PROD_W-1:0]        prod;                       // in-quadrant phase * 2pi
   logic [PROD_W-1:0]        prod_rnd;                   // rounded before the shift
   logic [DATA_W-1:0]        rad;                        // angle in 2^-16 rad, < pi/2
   logic signed [DATA_W-1:0] angle_q;
   quadrant_e                quad_q;

   assign capture  = i_req & ~req_q;                     // rising request only

   // phase/2^16 of a turn -> 2*pi*phase in 2^-16 rad
   assign prod     = PROD_W'(i_phase[PHASE_W-3:0]) * PROD_W'(TWO_PI_Q16);
   assign prod_rnd = prod + PROD_W'(1 << (FRAC_W - 1)); // half LSB
   assign rad      = DATA_W'(prod_rnd[PROD_W-1:FRAC_W]); // max 102938, zero extended

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         req_q <= 1'b0;
      end else begin
         req_q <= i_req;                                 // falls one edge after a drop
      end
   end

   always_ff @(posedge i_clk) begin
      if (capture) begin
         quad_q  <= quadrant_e'(i_phase[PHASE_W-1 -: 2]); // top two bits
         angle_q <= signed'(rad);
      end
   end

   assign fold.angle    = angle_q;
   assign fold.quadrant = quad_q;
   assign fold.start    = req_q;                         // held while request persists
   assign fold.abort    = ~req_q;                        // also high out of reset

endmodule

`default_nettype wire

//--- cordic_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator import cordic_pkg::*; #(
   parameter int N_ITER = 16
) (
   input  logic   i_clk,
   input  logic   i_nrst,
   cordic_if.rot  rot
);

   localparam logic [CNT_W-1:0] LAST = CNT_W'(N_ITER - 1);  // index of final step

   rot_state_e               state;
   logic [CNT_W-1:0]         count;                      // step index, also shift amount
   logic signed [DATA_W-1:0] beta;                       // accumulated angle
   logic signed [DATA_W-1:0] x_r;
   logic signed [DATA_W-1:0] y_r;
   logic signed [DATA_W-1:0] a;                          // arctan for this step
   logic signed [DATA_W-1:0] x_shift;
   logic signed [DATA_W-1:0] y_shift;
   logic signed [DATA_W-1:0] beta_new;
   logic signed [DATA_W-1:0] x_new;
   logic signed [DATA_W-1:0] y_new;
   logic                     sigma;                      // 1 = rotate counter-clockwise
   logic                     step_en;

   assign a        = atan_lut(count);
   assign x_shift  = x_r >>> count;                      // arithmetic, keeps sign
   assign y_shift  = y_r >>> count;

   // still below target -> rotate forward, else back
   assign sigma    = (beta > rot.angle) ? 1'b0 : 1'b1;
   assign beta_new = sigma ? beta + a    : beta - a;
   assign x_new    = sigma ? x_r - y_shift : x_r + y_shift;
   assign y_new    = sigma ? y_r + x_shift : y_r - x_shift;

   // step 0 happens on the edge that leaves IDLE
   assign step_en  = (state == ROTATE) || ((state == IDLE) && rot.start);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= IDLE;
         count <= '0;
         beta  <= '0;
         x_r   <= CORDIC_K_Q16;                          // gain folded into start vector
         y_r   <= '0;
      end else if (rot.abort) begin
         state <= IDLE;                                  // request dropped
         count <= '0;
         beta  <= '0;
         x_r   <= CORDIC_K_Q16;
         y_r   <= '0;
      end else begin
         if (step_en) begin
            count <= count + 1'b1;
            beta  <= beta_new;
            x_r   <= x_new;
            y_r   <= y_new;
         end
         case (state)
            IDLE: begin
               if (rot.start) begin
                  state <= ROTATE;
               end
            end
            ROTATE: begin
               if (count == LAST) begin
                  state <= DONE;                         // after step N_ITER-1
               end
            end
            default: begin
               state <= DONE;                            // hold until abort
            end
         endcase
      end
   end

   assign rot.done = (state == DONE);
   assign rot.x    = x_r;                                // cos of folded angle
   assign rot.y    = y_r;                                // sin of folded angle

endmodule

`default_nettype wire

//--- quadrant_unfold.sv
`timescale 1ns/1ps
`default_nettype none

module quadrant_unfold import cordic_pkg::*; (
   input  logic                     i_clk,
   input  logic                     i_nrst,
   cordic_if.unfold                 unf,
   output logic signed [DATA_W-1:0] o_sin,
   output logic signed [DATA_W-1:0] o_cos,
   output logic                     o_ack
);

   logic signed [DATA_W-1:0] sin_d;                      // sin in the true quadrant
   logic signed [DATA_W-1:0] cos_d;

   // rotate the first-quadrant vector by quadrant * pi/2
   always_comb begin
      case (unf.quadrant)
         Q1: begin
            cos_d = -unf.y;
            sin_d = unf.x;
         end
         Q2: begin
            cos_d = -unf.x;
            sin_d = -unf.y;
         end
         Q3: begin
            cos_d = unf.y;
            sin_d = -unf.x;
         end
         default: begin                                  // Q0, as computed
            cos_d = unf.x;
            sin_d = unf.y;
         end
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_sin <= '0;
         o_cos <= '0;
         o_ack <= 1'b0;
      end else if (unf.abort) begin
         o_ack <= 1'b0;                                  // last result left in place
      end else if (unf.done && !o_ack) begin
         o_sin <= sin_d;                                 // loaded once per request
         o_cos <= cos_d;
         o_ack <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- sincos_unit.sv
`timescale 1ns/1ps
`default_nettype none

module sincos_unit import cordic_pkg::*; #(
   parameter int N_ITER = ITER_N
) (
   input  logic                     i_clk,
   input  logic                     i_nrst,
   input  logic                     i_req,
   input  logic [PHASE_W-1:0]       i_phase,
   output logic signed [DATA_W-1:0] o_sin,
   output logic signed [DATA_W-1:0] o_cos,
   output logic                     o_ack
);

   cordic_if cif ();                                     // fold -> rotate -> unfold

   // edge 0: phase, quadrant and angle captured
   phase_fold u_fold (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_req   (i_req),
      .i_phase (i_phase),
      .fold    (cif.fold)
   );

   // edges 1 .. N_ITER: one micro-rotation each
   cordic_rotator #(
      .N_ITER (N_ITER)
   ) u_rot (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .rot    (cif.rot)
   );

   // one edge after done: outputs and ack
   quadrant_unfold u_unfold (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .unf    (cif.unfold),
      .o_sin  (o_sin),
      .o_cos  (o_cos),
      .o_ack  (o_ack)
   );

endmodule

`default_nettype wire

//--- tb_sincos.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sincos import cordic_pkg::*; ();

   localparam int LATENCY = 17;                          // first request edge to ack
   localparam int TOL     = 8;                           // LSB allowed on sin/cos
   localparam int N_NORM  = 8;                           // random phases for the norm test
   localparam longint NORM_REF = 64'd4294967296;         // 2^32
   localparam longint NORM_TOL = 64'd85899345;           // 2% of 2^32

   logic                     i_clk;
   logic                     i_nrst;
   logic                     i_req;
   logic [PHASE_W-1:0]       i_phase;
   logic signed [DATA_W-1:0] o_sin;
   logic signed [DATA_W-1:0] o_cos;
   logic                     o_ack;

   int kind_q[$];                                        // 0 axis, 1 rand, 2 abort
   int phase_q[$];
   int sin_q[$];
   int cos_q[$];
   int hold_q[$];
   int cycle_cnt;
   int limit;

   sincos_unit DUT (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_req   (i_req),
      .i_phase (i_phase),
      .o_sin   (o_sin),
      .o_cos   (o_cos),
      .o_ack   (o_ack)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;                        // 100 ns period
   end

   initial begin
      cycle_cnt = 0;
      forever begin
         @(posedge i_clk);
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt > limit) begin
            $display("timeout, the run took more than %0d cycles", limit);
            $display("Test FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
         end
      end
   end

   task automatic check_sample(input string name, input logic signed [DATA_W-1:0] exp,
                               input logic signed [DATA_W-1:0] act, input int tol);
      int diff;
      diff = int'(act) - int'(exp);
      if (diff > tol || diff < -tol) begin
         $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "result mismatch");
      end
   endtask

   task automatic check_ack(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s expected %0b actual %0b", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "ack mismatch");
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "latency mismatch");
      end
   endtask

   task automatic check_norm(input string name, input longint act);
      longint diff;
      diff = act - NORM_REF;
      if (diff > NORM_TOL || diff < -NORM_TOL) begin
         $display("[FAIL] %s expected %0d actual %0d", name, NORM_REF, act);
         $display("Test FAILED");
         $fatal(1, "vector length out of range");
      end
   endtask

   task automatic read_stimulus();
      int    fd;
      int    n;
      int    ph;
      int    s;
      int    c;
      int    h;
      string line;
      logic [63:0] kind;
      fd = $fopen("sincos_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open sincos_stimulus.txt");
         $display("Test FAILED");
         $fatal(1, "missing stimulus file");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line[0] == "#") continue; // comment or blank
         n = $sscanf(line, "%s %d %d %d %d", kind, ph, s, c, h);
         if (n != 5) continue;
         kind_q.push_back(kind == "axis" ? 0 : (kind == "rand" ? 1 : 2));
         phase_q.push_back(ph);
         sin_q.push_back(s);
         cos_q.push_back(c);
         hold_q.push_back(h);
      end
      $fclose(fd);
   endtask

   task automatic send_request(input logic [PHASE_W-1:0] ph);
      @(posedge i_clk);
      i_req   <= 1'b1;
      i_phase <= ph;
   endtask

   // request already driven; counts edges until ack is seen
   task automatic wait_ack(input string name);
      int cycles;
      cycles = 0;
      do begin
         @(posedge i_clk);
         cycles = cycles + 1;
         @(negedge i_clk);
      end while (!o_ack && cycles < 3 * LATENCY);
      check_count({name, " latency"}, LATENCY, cycles - 1); // first edge is edge 0
   endtask

   task automatic hold_and_release(input string name, input int hold);
      logic signed [DATA_W-1:0] s0;
      logic signed [DATA_W-1:0] c0;
      s0 = o_sin;
      c0 = o_cos;
      repeat (hold) begin
         @(posedge i_clk);
         @(negedge i_clk);
         check_ack({name, " ack hold"}, 1'b1, o_ack);
         check_sample({name, " sin hold"}, s0, o_sin, 0);
         check_sample({name, " cos hold"}, c0, o_cos, 0);
      end
      @(posedge i_clk);
      i_req <= 1'b0;
      @(posedge i_clk);                                  // drop sampled here
      @(posedge i_clk);
      @(negedge i_clk);
      check_ack({name, " ack release"}, 1'b0, o_ack);
   endtask

   initial begin
      string            name;
      int               total;
      logic [PHASE_W-1:0] ph;
      longint           s;
      longint           c;
      limit   = 1000000;                                 // replaced once the file is read
      i_nrst  = 1'b0;
      i_req   = 1'b0;
      i_phase = '0;
      void'($urandom(32'ha0d08f70));
      read_stimulus();
      total = 0;
      foreach (hold_q[k]) begin
         total = total + LATENCY + hold_q[k] + 6;
         if (kind_q[k] == 2) total = total + 12;         // aborted first request
      end
      limit = total + N_NORM * (LATENCY + 7) + 100;
      repeat (5) @(posedge i_clk);
      i_nrst <= 1'b1;
      @(negedge i_clk);
      check_ack("reset ack", 1'b0, o_ack);
      check_sample("reset sin", '0, o_sin, 0);
      check_sample("reset cos", '0, o_cos, 0);

      foreach (kind_q[k]) begin
         name = $sformatf("line%0d phase %0d", k, phase_q[k]);
         if (kind_q[k] == 2) begin
            send_request(PHASE_W'(phase_q[k]) ^ 16'h5a5a); // phase that gets cancelled
            repeat (8) begin
               @(posedge i_clk);
               @(negedge i_clk);
               check_ack({name, " ack before abort"}, 1'b0, o_ack);
            end
            @(posedge i_clk);
            i_req <= 1'b0;
            @(posedge i_clk);
         end
         send_request(PHASE_W'(phase_q[k]));
         wait_ack(name);
         check_sample({name, " sin"}, DATA_W'(sin_q[k]), o_sin, TOL);
         check_sample({name, " cos"}, DATA_W'(cos_q[k]), o_cos, TOL);
         hold_and_release(name, hold_q[k]);
      end

      repeat (N_NORM) begin
         ph   = PHASE_W'($urandom);
         name = $sformatf("norm phase %0d", ph);
         send_request(ph);
         wait_ack(name);
         s = longint'(o_sin);
         c = longint'(o_cos);
         check_norm(name, s * s + c * c);                // vector length squared
         hold_and_release(name, 1);
      end

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- sincos_stimulus.txt
# kind phase sin cos hold
# sin/cos = round(65536 * sin/cos(2*pi*phase/65536)), hold = cycles with ack held
axis 0 0 65536 2
axis 16384 65536 0 1
axis 32768 0 -65536 3
axis 49152 -65536 0 2
rand 1000 6274 65235 3
rand 8192 46341 46341 2
rand 20480 60547 -25080 4
rand 34816 -12785 -64277 1
rand 55296 -54491 36410 2
rand 26624 36410 -54491 3
rand 47104 -64277 -12785 2
rand 61440 -25080 60547 1
abort 12288 60547 25080 2
abort 40960 -46341 -46341 2

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, pass when the pass line is printed
verilator --binary --timing -f verilog.f --top-module tb_sincos -o tb_sincos \
   && ./obj_dir/tb_sincos | grep -q "Test OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- verilog.f
cordic_pkg.sv
cordic_if.sv
phase_fold.sv
cordic_rotator.sv
quadrant_unfold.sv
sincos_unit.sv
tb_sincos.sv
